//--- common/aq32_pkg.sv
package aq32_pkg;

    //////////////////////////////////////////////////
    // CPU bus
    //////////////////////////////////////////////////
    typedef logic [31:0] addr_t;     // Byte address
    typedef logic [31:0] data_t;
    typedef logic [3:0]  bytesel_t;  // One select per byte lane

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_SRAM,
        REGION_TRAM,
        REGION_CHRAM,
        REGION_VRAM,
        REGION_PAL,
        REGION_REGS
    } region_t;

    localparam addr_t SRAM_BASE  = 32'hFFF0_0000;  // External SRAM of 512KB
    localparam addr_t TRAM_BASE  = 32'hFF00_0000;
    localparam addr_t CHRAM_BASE = 32'hFF10_0000;
    localparam addr_t VRAM_BASE  = 32'hFF20_0000;
    localparam addr_t PAL_BASE   = 32'hFF40_0000;
    localparam addr_t REGS_BASE  = 32'hFF50_0000;

    // Window sizes in byte address bits
    localparam int SRAM_AW  = 19;
    localparam int TRAM_AW  = 12;
    localparam int CHRAM_AW = 11;
    localparam int VRAM_AW  = 14;
    localparam int PAL_AW   = 7;
    localparam int REGS_AW  = 14;

    // Video memory words
    typedef logic [15:0] tram_word_t;   // Char code and colour
    typedef logic [7:0]  chram_word_t;  // Font row
    typedef logic [15:0] pal_word_t;
    typedef logic [31:0] vram_word_t;

    //////////////////////////////////////////////////
    // Register block
    //////////////////////////////////////////////////
    localparam logic [5:0] REG_ESPCTRL  = 6'd0;
    localparam logic [5:0] REG_ESPDATA  = 6'd1;
    localparam logic [5:0] REG_VCTRL    = 6'd2;
    localparam logic [5:0] REG_VSCRX    = 6'd3;
    localparam logic [5:0] REG_VSCRY    = 6'd4;
    localparam logic [5:0] REG_VIRQLINE = 6'd6;

    typedef struct packed {
        logic       tram_page;
        logic       columns_80;
        logic       border_remap;
        logic       text_priority;
        logic       sprites_enable;
        logic [1:0] gfx_mode;
        logic       text_enable;
    } vctrl_t;

    // ESPCTRL status layout
    localparam int RX_OVERFLOW_BIT = 4;
    localparam int FRAMING_BIT     = 3;
    localparam int TX_FULL_BIT     = 1;
    localparam int RX_READY_BIT    = 0;

    typedef logic [8:0] esp_byte_t;  // Bit 8 flags a break/escape

endpackage

//--- verilog/aq32_video_ram.sv
module aq32_video_ram #(
    parameter type word_t    = aq32_pkg::vram_word_t,
    parameter int  ADDR_BITS = 12
) (
    input  logic                        clk,
    input  logic                        sel,
    input  logic                        wren,
    input  logic [ADDR_BITS-1:0]        addr,
    input  word_t                       wrdata,
    input  logic [$bits(word_t)/8-1:0]  byte_en,
    output word_t                       rddata
);

    localparam int WORD_BITS = $bits(word_t);
    localparam int BYTES     = WORD_BITS / 8;
    localparam int DEPTH     = 2 ** ADDR_BITS;

    word_t                 mem [DEPTH];
    logic [WORD_BITS-1:0]  wr_bits;
    logic [WORD_BITS-1:0]  merged;   // Stored word with written lanes replaced
    logic                  write;

    assign wr_bits = wrdata;
    assign write   = sel && wren;

    always_comb begin
        merged = mem[addr];
        if (write) begin
            for (int i = 0; i < BYTES; i++) begin
                if (byte_en[i])
                    merged[8*i +: 8] = wr_bits[8*i +: 8];
            end
        end
    end

    // Output register follows the address every cycle and takes new data on a write
    always_ff @(posedge clk) begin
        if (write)
            mem[addr] <= word_t'(merged);
        rddata <= word_t'(merged);
    end

endmodule

//--- interconnect/aq32_addr_decode.sv
module aq32_addr_decode (
    input  logic                   clk,
    input  logic                   reset,

    input  aq32_pkg::addr_t        cpu_addr,
    input  logic                   cpu_wren,
    input  logic                   cpu_strobe,
    output logic                   cpu_wait,
    output aq32_pkg::data_t        cpu_rddata,

    input  logic                   sram_wait,
    input  aq32_pkg::data_t        sram_rddata,
    output logic                   sram_strobe,

    output logic                   tram_sel,
    output logic                   chram_sel,
    output logic                   vram_sel,
    output logic                   pal_sel,
    output logic                   regs_sel,

    input  aq32_pkg::tram_word_t   tram_rddata,
    input  aq32_pkg::chram_word_t  chram_rddata,
    input  aq32_pkg::vram_word_t   vram_rddata,
    input  aq32_pkg::pal_word_t    pal_rddata,
    input  aq32_pkg::data_t        regs_rddata
);

    aq32_pkg::region_t region;
    aq32_pkg::addr_t   q_addr;     // Address seen in the previous cycle
    aq32_pkg::addr_t   addr_diff;

    // High bits above the window match the base
    function automatic logic in_window(aq32_pkg::addr_t addr, aq32_pkg::addr_t base, int aw);
        return (addr >> aw) == (base >> aw);
    endfunction

    // Any difference inside the low aw bits
    function automatic logic moved(aq32_pkg::addr_t diff, int aw);
        return (diff & ((32'd1 << aw) - 32'd1)) != 32'd0;
    endfunction

    always_comb begin
        region = aq32_pkg::REGION_NONE;
        if (in_window(cpu_addr, aq32_pkg::SRAM_BASE, aq32_pkg::SRAM_AW))
            region = aq32_pkg::REGION_SRAM;
        else if (in_window(cpu_addr, aq32_pkg::TRAM_BASE, aq32_pkg::TRAM_AW))
            region = aq32_pkg::REGION_TRAM;
        else if (in_window(cpu_addr, aq32_pkg::CHRAM_BASE, aq32_pkg::CHRAM_AW))
            region = aq32_pkg::REGION_CHRAM;
        else if (in_window(cpu_addr, aq32_pkg::VRAM_BASE, aq32_pkg::VRAM_AW))
            region = aq32_pkg::REGION_VRAM;
        else if (in_window(cpu_addr, aq32_pkg::PAL_BASE, aq32_pkg::PAL_AW))
            region = aq32_pkg::REGION_PAL;
        else if (in_window(cpu_addr, aq32_pkg::REGS_BASE, aq32_pkg::REGS_AW))
            region = aq32_pkg::REGION_REGS;
    end

    assign sram_strobe = cpu_strobe && region == aq32_pkg::REGION_SRAM;
    assign tram_sel    = cpu_strobe && region == aq32_pkg::REGION_TRAM;
    assign chram_sel   = cpu_strobe && region == aq32_pkg::REGION_CHRAM;
    assign vram_sel    = cpu_strobe && region == aq32_pkg::REGION_VRAM;
    assign pal_sel     = cpu_strobe && region == aq32_pkg::REGION_PAL;
    assign regs_sel    = cpu_strobe && region == aq32_pkg::REGION_REGS;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            q_addr <= '0;
        else
            q_addr <= cpu_addr;
    end

    assign addr_diff = cpu_addr ^ q_addr;

    //////////////////////////////////////////////////
    // RAM output register lags the address by one cycle
    always_comb begin
        cpu_wait = 1'b0;
        if (cpu_strobe) begin
            case (region)
                aq32_pkg::REGION_SRAM:  cpu_wait = sram_wait;
                aq32_pkg::REGION_TRAM:  cpu_wait = !cpu_wren && moved(addr_diff, aq32_pkg::TRAM_AW);
                aq32_pkg::REGION_CHRAM: cpu_wait = !cpu_wren && moved(addr_diff, aq32_pkg::CHRAM_AW);
                aq32_pkg::REGION_VRAM:  cpu_wait = !cpu_wren && moved(addr_diff, aq32_pkg::VRAM_AW);
                aq32_pkg::REGION_PAL:   cpu_wait = !cpu_wren && moved(addr_diff, aq32_pkg::PAL_AW);
                default:                cpu_wait = 1'b0;  // Registers and unmapped
            endcase
        end
    end

    // Narrow words replicated over all lanes
    always_comb begin
        cpu_rddata = '0;
        if (cpu_strobe) begin
            case (region)
                aq32_pkg::REGION_SRAM:  cpu_rddata = sram_rddata;
                aq32_pkg::REGION_TRAM:  cpu_rddata = {2{tram_rddata}};
                aq32_pkg::REGION_CHRAM: cpu_rddata = {4{chram_rddata}};
                aq32_pkg::REGION_VRAM:  cpu_rddata = vram_rddata;
                aq32_pkg::REGION_PAL:   cpu_rddata = {2{pal_rddata}};
                aq32_pkg::REGION_REGS:  cpu_rddata = regs_rddata;
                default:                cpu_rddata = '0;
            endcase
        end
    end

endmodule

//--- regs/aq32_regs.sv
module aq32_regs (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 sel,
    input  logic                 wren,
    input  logic [5:0]           index,
    input  aq32_pkg::data_t      wrdata,
    output aq32_pkg::data_t      rddata,

    // ESP UART FIFO ports
    output aq32_pkg::esp_byte_t  esp_tx_data,
    output logic                 esp_tx_wr,
    input  logic                 esp_tx_full,
    input  aq32_pkg::esp_byte_t  esp_rx_data,
    input  logic                 esp_rx_empty,
    output logic                 esp_rx_rd,
    input  logic                 esp_rx_overflow,
    input  logic                 esp_framing_error,

    // Video control levels
    output aq32_pkg::vctrl_t     vctrl,
    output logic [8:0]           vscrx,
    output logic [7:0]           vscry,
    output logic [7:0]           virqline
);

    logic            reg_wr;
    logic            espctrl_wr;
    logic            espdata_sel;
    logic            q_rx_overflow;   // Sticky until written with one
    logic            q_framing_error;
    aq32_pkg::data_t esp_status;

    assign reg_wr      = sel && wren;
    assign espctrl_wr  = reg_wr && index == aq32_pkg::REG_ESPCTRL;
    assign espdata_sel = sel && index == aq32_pkg::REG_ESPDATA;

    // FIFO strobes straight from the bus cycle
    assign esp_tx_data = wrdata[8:0];
    assign esp_tx_wr   = espdata_sel && wren;
    assign esp_rx_rd   = espdata_sel && !wren;

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vctrl    <= '0;
            vscrx    <= '0;
            vscry    <= '0;
            virqline <= '0;
        end else if (reg_wr) begin
            case (index)
                aq32_pkg::REG_VCTRL:    vctrl    <= aq32_pkg::vctrl_t'(wrdata[7:0]);
                aq32_pkg::REG_VSCRX:    vscrx    <= wrdata[8:0];
                aq32_pkg::REG_VSCRY:    vscry    <= wrdata[7:0];
                aq32_pkg::REG_VIRQLINE: virqline <= wrdata[7:0];
                default: ;
            endcase
        end
    end

    // Set pulse beats a clear in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_rx_overflow   <= 1'b0;
            q_framing_error <= 1'b0;
        end else begin
            if (esp_rx_overflow)
                q_rx_overflow <= 1'b1;
            else if (espctrl_wr && wrdata[aq32_pkg::RX_OVERFLOW_BIT])
                q_rx_overflow <= 1'b0;

            if (esp_framing_error)
                q_framing_error <= 1'b1;
            else if (espctrl_wr && wrdata[aq32_pkg::FRAMING_BIT])
                q_framing_error <= 1'b0;
        end
    end

    always_comb begin
        esp_status = '0;
        esp_status[aq32_pkg::RX_OVERFLOW_BIT] = q_rx_overflow;
        esp_status[aq32_pkg::FRAMING_BIT]     = q_framing_error;
        esp_status[aq32_pkg::TX_FULL_BIT]     = esp_tx_full;
        esp_status[aq32_pkg::RX_READY_BIT]    = !esp_rx_empty;
    end

    // Zero extended read back with index 5 and the gaps at zero
    always_comb begin
        case (index)
            aq32_pkg::REG_ESPCTRL:  rddata = esp_status;
            aq32_pkg::REG_ESPDATA:  rddata = {23'd0, esp_rx_data};
            aq32_pkg::REG_VCTRL:    rddata = {24'd0, vctrl};
            aq32_pkg::REG_VSCRX:    rddata = {23'd0, vscrx};
            aq32_pkg::REG_VSCRY:    rddata = {24'd0, vscry};
            aq32_pkg::REG_VIRQLINE: rddata = {24'd0, virqline};
            default:                rddata = '0;
        endcase
    end

endmodule

//--- verilog/aq32_bus_top.sv
module aq32_bus_top (
    input  logic                          clk,
    input  logic                          reset,

    // CPU bus
    input  aq32_pkg::addr_t               cpu_addr,
    input  aq32_pkg::data_t               cpu_wrdata,
    input  aq32_pkg::bytesel_t            cpu_bytesel,
    input  logic                          cpu_wren,
    input  logic                          cpu_strobe,
    output logic                          cpu_wait,
    output aq32_pkg::data_t               cpu_rddata,

    // External SRAM controller
    output logic                          sram_strobe,
    output logic [aq32_pkg::SRAM_AW-3:0]  sram_addr,
    output aq32_pkg::data_t               sram_wrdata,
    output aq32_pkg::bytesel_t            sram_bytesel,
    output logic                          sram_wren,
    input  logic                          sram_wait,
    input  aq32_pkg::data_t               sram_rddata,

    // ESP UART FIFOs
    output aq32_pkg::esp_byte_t           esp_tx_data,
    output logic                          esp_tx_wr,
    input  logic                          esp_tx_full,
    input  aq32_pkg::esp_byte_t           esp_rx_data,
    input  logic                          esp_rx_empty,
    output logic                          esp_rx_rd,
    input  logic                          esp_rx_overflow,
    input  logic                          esp_framing_error,

    // Video control
    output aq32_pkg::vctrl_t              vctrl,
    output logic [8:0]                    vscrx,
    output logic [7:0]                    vscry,
    output logic [7:0]                    virqline
);

    // Word address widths inside each window
    localparam int TRAM_ABITS  = aq32_pkg::TRAM_AW - 1;
    localparam int CHRAM_ABITS = aq32_pkg::CHRAM_AW;
    localparam int VRAM_ABITS  = aq32_pkg::VRAM_AW - 2;
    localparam int PAL_ABITS   = aq32_pkg::PAL_AW - 1;

    logic tram_sel, chram_sel, vram_sel, pal_sel, regs_sel;

    aq32_pkg::tram_word_t  tram_rddata;
    aq32_pkg::chram_word_t chram_rddata;
    aq32_pkg::vram_word_t  vram_rddata;
    aq32_pkg::pal_word_t   pal_rddata;
    aq32_pkg::data_t       regs_rddata;

    // SRAM command copied from the bus
    assign sram_addr    = cpu_addr[aq32_pkg::SRAM_AW-1:2];
    assign sram_wrdata  = cpu_wrdata;
    assign sram_bytesel = cpu_bytesel;
    assign sram_wren    = cpu_wren;

    aq32_addr_decode u_decode (
        .clk(clk), .reset(reset),
        .cpu_addr(cpu_addr), .cpu_wren(cpu_wren), .cpu_strobe(cpu_strobe),
        .cpu_wait(cpu_wait), .cpu_rddata(cpu_rddata),
        .sram_wait(sram_wait), .sram_rddata(sram_rddata), .sram_strobe(sram_strobe),
        .tram_sel(tram_sel), .chram_sel(chram_sel), .vram_sel(vram_sel),
        .pal_sel(pal_sel), .regs_sel(regs_sel),
        .tram_rddata(tram_rddata), .chram_rddata(chram_rddata),
        .vram_rddata(vram_rddata), .pal_rddata(pal_rddata),
        .regs_rddata(regs_rddata));

    //////////////////////////////////////////////////
    // Video memories
    //////////////////////////////////////////////////
    // Narrow memories always write the whole word
    aq32_video_ram #(.word_t(aq32_pkg::tram_word_t), .ADDR_BITS(TRAM_ABITS)) u_tram (
        .clk(clk), .sel(tram_sel), .wren(cpu_wren),
        .addr(cpu_addr[aq32_pkg::TRAM_AW-1:1]), .wrdata(cpu_wrdata[15:0]),
        .byte_en(2'b11), .rddata(tram_rddata));

    aq32_video_ram #(.word_t(aq32_pkg::chram_word_t), .ADDR_BITS(CHRAM_ABITS)) u_chram (
        .clk(clk), .sel(chram_sel), .wren(cpu_wren),
        .addr(cpu_addr[aq32_pkg::CHRAM_AW-1:0]), .wrdata(cpu_wrdata[7:0]),
        .byte_en(1'b1), .rddata(chram_rddata));

    aq32_video_ram #(.word_t(aq32_pkg::vram_word_t), .ADDR_BITS(VRAM_ABITS)) u_vram (
        .clk(clk), .sel(vram_sel), .wren(cpu_wren),
        .addr(cpu_addr[aq32_pkg::VRAM_AW-1:2]), .wrdata(cpu_wrdata),
        .byte_en(cpu_bytesel), .rddata(vram_rddata));  // Byte writes only here

    aq32_video_ram #(.word_t(aq32_pkg::pal_word_t), .ADDR_BITS(PAL_ABITS)) u_pal (
        .clk(clk), .sel(pal_sel), .wren(cpu_wren),
        .addr(cpu_addr[aq32_pkg::PAL_AW-1:1]), .wrdata(cpu_wrdata[15:0]),
        .byte_en(2'b11), .rddata(pal_rddata));

    aq32_regs u_regs (
        .clk(clk), .reset(reset),
        .sel(regs_sel), .wren(cpu_wren), .index(cpu_addr[7:2]),
        .wrdata(cpu_wrdata), .rddata(regs_rddata),
        .esp_tx_data(esp_tx_data), .esp_tx_wr(esp_tx_wr), .esp_tx_full(esp_tx_full),
        .esp_rx_data(esp_rx_data), .esp_rx_empty(esp_rx_empty), .esp_rx_rd(esp_rx_rd),
        .esp_rx_overflow(esp_rx_overflow), .esp_framing_error(esp_framing_error),
        .vctrl(vctrl), .vscrx(vscrx), .vscry(vscry), .virqline(virqline));

endmodule

//--- sim/aq32_bus_checker.sv
module aq32_bus_checker (
    input  logic               clk,
    input  logic               reset,
    input  logic               cpu_strobe,
    input  logic               cpu_wren,
    input  logic               cpu_wait,
    input  logic               sram_strobe,
    input  logic               tram_sel,
    input  logic               chram_sel,
    input  logic               vram_sel,
    input  logic               pal_sel,
    input  logic               regs_sel,
    input  aq32_pkg::region_t  region
);

    logic internal_sel;

    assign internal_sel = tram_sel || chram_sel || vram_sel || pal_sel || regs_sel;

    one_region: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sram_strobe, tram_sel, chram_sel, vram_sel, pal_sel, regs_sel}))
        else $error("more than one region select is high");

    idle_no_wait: assert property (@(posedge clk) disable iff (reset)
        !cpu_strobe |-> !cpu_wait)
        else $error("wait high without strobe");

    write_no_wait: assert property (@(posedge clk) disable iff (reset)
        (internal_sel && cpu_wren) |-> !cpu_wait)
        else $error("write to an internal region waited");

    sram_only: assert property (@(posedge clk) disable iff (reset)
        sram_strobe |-> region == aq32_pkg::REGION_SRAM)
        else $error("sram_strobe outside the SRAM window");

endmodule

bind aq32_addr_decode aq32_bus_checker u_bus_checker (.*);

//--- sim/aq32_tb.sv
module aq32_tb;

    localparam int N_RAM  = 200;
    localparam int N_SRAM = 40;
    localparam int N_REG  = 40;
    localparam int N_ESP  = 20;
    // Each access is at most a drive cycle plus four waits
    localparam int LIMIT  = 2 * (20 + N_RAM * 2 * 3 + N_SRAM * 6 + N_REG * 4 + N_ESP * 8 + 40);

    logic clk = 1'b0;
    logic reset;
    aq32_pkg::addr_t    cpu_addr;
    aq32_pkg::data_t    cpu_wrdata;
    aq32_pkg::bytesel_t cpu_bytesel;
    logic               cpu_wren;
    logic               cpu_strobe;
    logic               cpu_wait;
    aq32_pkg::data_t    cpu_rddata;
    logic               sram_strobe;
    logic [16:0]        sram_addr;
    aq32_pkg::data_t    sram_wrdata;
    aq32_pkg::bytesel_t sram_bytesel;
    logic               sram_wren;
    logic               sram_wait;
    aq32_pkg::data_t    sram_rddata;
    aq32_pkg::esp_byte_t esp_tx_data;
    logic               esp_tx_wr;
    logic               esp_tx_full;
    aq32_pkg::esp_byte_t esp_rx_data;
    logic               esp_rx_empty;
    logic               esp_rx_rd;
    logic               esp_rx_overflow;
    logic               esp_framing_error;
    aq32_pkg::vctrl_t   vctrl;
    logic [8:0]         vscrx;
    logic [7:0]         vscry;
    logic [7:0]         virqline;

    // Models
    aq32_pkg::data_t ram_m [aq32_pkg::addr_t];
    int              ram_r [aq32_pkg::addr_t];  // Region index of each written word
    aq32_pkg::addr_t written_q [$];
    aq32_pkg::data_t sram_m [int];
    aq32_pkg::data_t reg_m [int];
    aq32_pkg::addr_t base_a [4] = '{aq32_pkg::TRAM_BASE, aq32_pkg::CHRAM_BASE,
                                    aq32_pkg::VRAM_BASE, aq32_pkg::PAL_BASE};
    int aw_a [4] = '{aq32_pkg::TRAM_AW, aq32_pkg::CHRAM_AW, aq32_pkg::VRAM_AW, aq32_pkg::PAL_AW};
    int nb_a [4] = '{2, 1, 4, 2};       // Bytes per word
    int idx_a [4] = '{2, 3, 4, 6};
    aq32_pkg::data_t mask_a [4] = '{32'hFF, 32'h1FF, 32'hFF, 32'hFF};
    logic ovf_m, frm_m;

    int seed, errors, test_errors, tests, failed, cycles;
    int r, n, w, exp_w, k;
    aq32_pkg::addr_t prev_addr, a, ra, off, win;
    aq32_pkg::data_t d, rd, old;
    aq32_pkg::bytesel_t bs;
    logic we;

    aq32_bus_top DUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check(input string name, input aq32_pkg::data_t exp,
                         input aq32_pkg::data_t act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s %s", name, errors == test_errors ? "ok" : "failed");
        tests++;
        if (errors != test_errors)
            failed++;
        test_errors = errors;
    endtask

    // Returns at the falling edge of the completing cycle with the bus still driven
    task automatic bus_access(input aq32_pkg::addr_t ad, input aq32_pkg::data_t wd,
                              input aq32_pkg::bytesel_t bsel, input logic wr, input int delay,
                              input aq32_pkg::data_t srd, output aq32_pkg::data_t rdat,
                              output int waits);
        int left;
        left  = delay;
        waits = 0;
        @(posedge clk);
        cpu_addr    <= ad;
        cpu_wrdata  <= wd;
        cpu_bytesel <= bsel;
        cpu_wren    <= wr;
        cpu_strobe  <= 1'b1;
        sram_wait   <= left > 0;
        sram_rddata <= srd;
        @(negedge clk);
        while (cpu_wait && waits <= 8) begin
            waits++;
            @(posedge clk);
            left--;
            sram_wait <= left > 0;
            @(negedge clk);
        end
        if (waits > 8) begin
            $display("Access to %h never completed, cpu_wait stayed high", ad);
            errors++;
        end
        rdat      = cpu_rddata;
        prev_addr = ad;
    endtask

    task automatic idle();
        @(posedge clk);
        cpu_strobe        <= 1'b0;
        sram_wait         <= 1'b0;
        esp_rx_overflow   <= 1'b0;
        esp_framing_error <= 1'b0;
        @(negedge clk);
    endtask

    function automatic aq32_pkg::data_t replicate(input aq32_pkg::data_t wd, input int nb);
        if (nb == 1)
            return {4{wd[7:0]}};
        else if (nb == 2)
            return {2{wd[15:0]}};
        return wd;
    endfunction

    // Fill depends on every address bit
    function automatic aq32_pkg::data_t sram_fill(input int wa);
        return (wa * 32'h9E37_79B9) ^ {wa[15:0], ~wa[15:0]};
    endfunction

    function automatic aq32_pkg::data_t esp_status();
        aq32_pkg::data_t s;
        s = '0;
        s[aq32_pkg::RX_OVERFLOW_BIT] = ovf_m;
        s[aq32_pkg::FRAMING_BIT]     = frm_m;
        s[aq32_pkg::TX_FULL_BIT]     = esp_tx_full;
        s[aq32_pkg::RX_READY_BIT]    = !esp_rx_empty;
        return s;
    endfunction

    initial begin
        seed = 32'h2681_4a93;
        errors = 0;
        test_errors = 0;
        tests = 0;
        failed = 0;
        cycles = 0;
        reset = 1'b1;
        cpu_addr = '0;
        cpu_wrdata = '0;
        cpu_bytesel = '0;
        cpu_wren = 1'b0;
        cpu_strobe = 1'b0;
        sram_wait = 1'b0;
        sram_rddata = '0;
        esp_tx_full = 1'b0;
        esp_rx_data = '0;
        esp_rx_empty = 1'b1;
        esp_rx_overflow = 1'b0;
        esp_framing_error = 1'b0;
        prev_addr = '0;
        ovf_m = 1'b0;
        frm_m = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        //////////////////////////////////////////////////
        @(negedge clk);
        check("vctrl", 0, vctrl);
        check("vscrx", 0, vscrx);
        check("vscry", 0, vscry);
        check("virqline", 0, virqline);
        check("cpu_wait", 0, cpu_wait);
        check("esp_tx_wr", 0, esp_tx_wr);
        check("esp_rx_rd", 0, esp_rx_rd);
        check("sram_strobe", 0, sram_strobe);
        for (k = 0; k < 7; k++) begin
            bus_access(aq32_pkg::REGS_BASE | (k << 2), 0, 0, 1'b0, 0, 0, rd, w);
            check("cpu_rddata", 0, rd);
        end
        idle();
        finish_test("reset");

        //////////////////////////////////////////////////
        for (k = 0; k < N_RAM; k++) begin
            r   = $unsigned($random(seed)) % 4;
            off = $random(seed) & ((32'd1 << aw_a[r]) - 1) & ~(nb_a[r] - 1);
            a   = base_a[r] | off;
            d   = $random(seed);
            bs  = (r == 2 && ram_m.exists(a)) ? 4'($random(seed)) : 4'hF;
            old = ram_m.exists(a) ? ram_m[a] : '0;
            for (n = 0; n < 4; n++)
                if (bs[n] && n < nb_a[r])
                    old[8*n +: 8] = d[8*n +: 8];
            ram_m[a] = old;
            if (!ram_r.exists(a))
                written_q.push_back(a);
            ram_r[a] = r;
            bus_access(a, d, bs, 1'b1, 0, 0, rd, w);
            check("write cpu_wait cycles", 0, w);
            if ($random(seed) & 1)
                ra = a;
            else
                ra = written_q[$unsigned($random(seed)) % written_q.size()];
            r   = ram_r[ra];
            // A new offset inside the window costs one wait
            win = 32'd1 << aw_a[r];
            exp_w = (ra % win) != (prev_addr % win);
            bus_access(ra, 0, 0, 1'b0, 0, 0, rd, w);
            check("read cpu_wait cycles", exp_w, w);
            check("cpu_rddata", replicate(ram_m[ra], nb_a[r]), rd);
        end
        idle();
        finish_test("ram");

        //////////////////////////////////////////////////
        for (k = 0; k < N_SRAM; k++) begin
            off = $random(seed) & 32'h7FFFC;
            a   = aq32_pkg::SRAM_BASE | off;
            we  = 1'($random(seed));
            d   = $random(seed);
            bs  = 4'($random(seed));
            n   = $unsigned($random(seed)) % 4;
            old = sram_m.exists(off >> 2) ? sram_m[off >> 2] : sram_fill(off >> 2);
            bus_access(a, d, bs, we, n, old, rd, w);
            check("sram_strobe", 1, sram_strobe);
            check("sram_addr", off >> 2, sram_addr);
            check("sram_bytesel", bs, sram_bytesel);
            check("sram_wrdata", d, sram_wrdata);
            check("sram_wren", we, sram_wren);
            check("cpu_wait cycles", n, w);
            if (!we)
                check("cpu_rddata", old, rd);
            for (r = 0; r < 4; r++)
                if (bs[r])
                    old[8*r +: 8] = d[8*r +: 8];
            if (we)
                sram_m[off >> 2] = old;
        end
        idle();
        finish_test("sram");

        //////////////////////////////////////////////////
        for (k = 0; k < 4; k++)
            reg_m[k] = '0;
        for (k = 0; k < N_REG; k++) begin
            r = $unsigned($random(seed)) % 4;
            d = $random(seed);
            reg_m[r] = d & mask_a[r];
            bus_access(aq32_pkg::REGS_BASE | (idx_a[r] << 2), d, 4'hF, 1'b1, 0, 0, rd, w);
            idle();
            check("vctrl", reg_m[0], 32'(vctrl));
            check("vscrx", reg_m[1], vscrx);
            check("vscry", reg_m[2], vscry);
            check("virqline", reg_m[3], virqline);
            bus_access(aq32_pkg::REGS_BASE | (idx_a[r] << 2), 0, 0, 1'b0, 0, 0, rd, w);
            check("register read", reg_m[r], rd);
            check("cpu_wait cycles", 0, w);
        end
        bus_access(aq32_pkg::REGS_BASE | (5 << 2), 0, 0, 1'b0, 0, 0, rd, w);
        check("index 5 read", 0, rd);
        check("cpu_wait cycles", 0, w);
        bus_access(32'h0000_1000, 0, 0, 1'b0, 0, 0, rd, w);
        check("unmapped read", 0, rd);
        check("cpu_wait cycles", 0, w);
        idle();
        finish_test("vregs");

        //////////////////////////////////////////////////
        for (k = 0; k < N_ESP; k++) begin
            @(posedge clk);
            esp_tx_full  <= 1'($random(seed));
            esp_rx_empty <= 1'($random(seed));
            esp_rx_data  <= 9'($random(seed));
            bus_access(aq32_pkg::REGS_BASE, 0, 0, 1'b0, 0, 0, rd, w);
            check("espctrl", esp_status(), rd);
            bus_access(aq32_pkg::REGS_BASE | 4, 0, 0, 1'b0, 0, 0, rd, w);
            check("espdata", esp_rx_data, rd);
            check("esp_rx_rd", 1, esp_rx_rd);
            d = $random(seed);
            bus_access(aq32_pkg::REGS_BASE | 4, d, 4'hF, 1'b1, 0, 0, rd, w);
            check("esp_tx_wr", 1, esp_tx_wr);
            check("esp_tx_data", d[8:0], esp_tx_data);
            idle();
            check("esp_tx_wr", 0, esp_tx_wr);
            check("esp_rx_rd", 0, esp_rx_rd);
        end
        @(posedge clk) esp_rx_overflow <= 1'b1;
        @(posedge clk) esp_rx_overflow <= 1'b0;
        ovf_m = 1'b1;
        bus_access(aq32_pkg::REGS_BASE, 0, 0, 1'b0, 0, 0, rd, w);
        check("espctrl overflow set", esp_status(), rd);
        @(posedge clk) esp_framing_error <= 1'b1;
        frm_m = 1'b1;
        // Clear both while the framing pulse is still high
        bus_access(aq32_pkg::REGS_BASE, 32'h18, 4'hF, 1'b1, 0, 0, rd, w);
        idle();
        ovf_m = 1'b0;
        bus_access(aq32_pkg::REGS_BASE, 0, 0, 1'b0, 0, 0, rd, w);
        check("espctrl pulse beats clear", esp_status(), rd);
        bus_access(aq32_pkg::REGS_BASE, 32'h08, 4'hF, 1'b1, 0, 0, rd, w);
        frm_m = 1'b0;
        bus_access(aq32_pkg::REGS_BASE, 0, 0, 1'b0, 0, 0, rd, w);
        check("espctrl framing cleared", esp_status(), rd);
        idle();
        finish_test("esp");

        $display("tests %0d failed %0d errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- sources.f
common/aq32_pkg.sv
verilog/aq32_video_ram.sv
interconnect/aq32_addr_decode.sv
regs/aq32_regs.sv
verilog/aq32_bus_top.sv
sim/aq32_bus_checker.sv
sim/aq32_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert --timing -Wno-fatal
TOP       = aq32_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
